//--- hdl/osiris_cfg_pkg.sv
package osiris_cfg_pkg;

    // --------------------
    // Serial line timing
    // --------------------
    localparam int unsigned CLOCK_FREQ = 10_000_000;   // clk frequency in Hz
    localparam int unsigned BAUD_RATE  = 115_200;
    // Rounded to the nearest clock, 87 at these rates
    localparam int unsigned CLKS_PER_BIT = (CLOCK_FREQ + BAUD_RATE / 2) / BAUD_RATE;
    localparam int unsigned BAUD_CNT_WIDTH = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_CNT_WIDTH-1:0] BIT_LAST = BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_WIDTH-1:0] BIT_MID  = BAUD_CNT_WIDTH'(CLKS_PER_BIT / 2);

    // --------------------
    // Memory geometry
    // --------------------
    localparam int unsigned INST_MEM_SIZE_KB = 2;
    localparam int unsigned DATA_MEM_SIZE_KB = 2;
    localparam int unsigned WORD_BYTES       = 4;      // 32-bit words
    localparam int unsigned INST_MEM_DEPTH   = (INST_MEM_SIZE_KB * 1024) / WORD_BYTES;
    localparam int unsigned DATA_MEM_DEPTH   = (DATA_MEM_SIZE_KB * 1024) / WORD_BYTES;
    localparam int unsigned INST_ADDR_WIDTH  = $clog2(INST_MEM_DEPTH);
    localparam int unsigned DATA_ADDR_WIDTH  = $clog2(DATA_MEM_DEPTH);

    // --------------------
    // Frame format
    // --------------------
    localparam logic [7:0]  CMD_READ         = 8'h01;  // Answer with 4 data bytes
    localparam logic [7:0]  CMD_WRITE        = 8'hAA;  // Followed by 4 data bytes
    localparam int unsigned FRAME_ADDR_BYTES = 2;      // Word index, MSB first

endpackage

//--- hdl/osiris_bus_pkg.sv
package osiris_bus_pkg;

    typedef logic [7:0]  byte_t;   // One serial byte
    typedef logic [31:0] word_t;   // One memory word

    // Target memory of a frame, sampled with the command byte
    typedef enum logic {
        INST_MEM = 1'b0,
        DATA_MEM = 1'b1
    } mem_sel_t;

    // --------------------
    // Sequencer to bank
    // --------------------
    typedef struct packed {
        mem_sel_t sel;
        logic     we;                                                // 1 = write
        logic [osiris_cfg_pkg::FRAME_ADDR_BYTES*8-1:0] addr;         // Word index from frame
        word_t    wdata;
    } mem_req_t;

    // Bank to sequencer, valid while ack is high
    typedef struct packed {
        word_t rdata;
    } mem_rsp_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  rx_i,       // Asynchronous serial line
    output osiris_bus_pkg::byte_t byte_o,
    output logic                  valid_o     // One-cycle pulse per good frame
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                                 state_q;
    logic                                      rx_meta_q;
    logic                                      rx_sync_q;
    logic [osiris_cfg_pkg::BAUD_CNT_WIDTH-1:0] cnt_q;     // Clocks within the bit
    logic [2:0]                                bit_q;     // Data bit index
    osiris_bus_pkg::byte_t                     shift_q;

    // --------------------
    // Line synchronizer
    // --------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;   // Idle line is high
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            cnt_q   <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_sync_q) begin
                        state_q <= RX_START;   // Falling edge of a start bit
                    end
                end
                RX_START: begin
                    if (cnt_q == osiris_cfg_pkg::BIT_MID) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (cnt_q == osiris_cfg_pkg::BIT_LAST) begin   // Middle of a data bit
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (cnt_q == osiris_cfg_pkg::BIT_LAST) begin   // Middle of stop bit
                        valid_o <= rx_sync_q;    // Framing error drops the byte
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, shift right
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && cnt_q == osiris_cfg_pkg::BIT_LAST) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    assign byte_o = shift_q;

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  req_i,     // Four-phase request
    input  osiris_bus_pkg::byte_t byte_i,    // Stable while req is high
    output logic                  ack_o,     // High after the stop bit until req falls
    output logic                  tx_o
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_DONE
    } tx_state_t;

    tx_state_t                                 state_q;
    logic [9:0]                                frame_q;   // Stop, data, start; bit 0 on the line
    logic [osiris_cfg_pkg::BAUD_CNT_WIDTH-1:0] cnt_q;
    logic [3:0]                                bit_q;     // 0 start, 1..8 data, 9 stop

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= TX_IDLE;
            frame_q <= '1;        // Line idles high
            cnt_q   <= '0;
            bit_q   <= '0;
            ack_o   <= 1'b0;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (req_i) begin
                        frame_q <= {1'b1, byte_i, 1'b0};   // Start bit goes out next cycle
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        state_q <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == osiris_cfg_pkg::BIT_LAST) begin
                        cnt_q   <= '0;
                        bit_q   <= bit_q + 1'b1;
                        frame_q <= {1'b1, frame_q[9:1]};   // Ones fill in behind
                        if (bit_q == 4'd9) begin
                            ack_o   <= 1'b1;                // Whole frame is out
                            state_q <= TX_DONE;
                        end
                    end
                end
                default: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    assign tx_o = frame_q[0];

endmodule

//--- hdl/uart_cmd_sequencer.sv
`timescale 1ns/1ns

module uart_cmd_sequencer (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  osiris_bus_pkg::byte_t    rx_byte_i,
    input  logic                     rx_valid_i,      // No back-pressure
    input  logic                     select_mem_i,    // 0 = instruction, 1 = data
    input  logic                     start_rx_i,      // Low blocks new frames
    output osiris_bus_pkg::mem_req_t mem_req_o,
    output logic                     mem_req_valid_o,
    input  osiris_bus_pkg::mem_rsp_t mem_rsp_i,
    input  logic                     mem_ack_i,
    output osiris_bus_pkg::byte_t    tx_byte_o,
    output logic                     tx_req_o,
    input  logic                     tx_ack_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_MEM_REQ,
        S_MEM_REL,
        S_SEND,
        S_SEND_REL
    } seq_state_t;

    seq_state_t                state_q;
    logic [2:0]                byte_cnt_q;   // Bytes taken or sent in this phase
    logic                      we_q;
    osiris_bus_pkg::mem_sel_t  sel_q;
    logic [15:0]               addr_q;
    osiris_bus_pkg::word_t     word_q;       // Write data, then read byte shifter
    logic                      frame_start;

    assign frame_start = rx_valid_i && start_rx_i;

    // --------------------
    // Frame FSM
    // --------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q         <= S_IDLE;
            byte_cnt_q      <= '0;
            mem_req_valid_o <= 1'b0;
            tx_req_o        <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    byte_cnt_q <= '0;
                    if (frame_start && (rx_byte_i == osiris_cfg_pkg::CMD_WRITE ||
                                        rx_byte_i == osiris_cfg_pkg::CMD_READ)) begin
                        state_q <= S_ADDR;   // Unknown commands stay here
                    end
                end
                S_ADDR: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 3'(osiris_cfg_pkg::FRAME_ADDR_BYTES - 1)) begin
                            byte_cnt_q <= '0;
                            if (we_q) begin
                                state_q <= S_DATA;
                            end else begin
                                mem_req_valid_o <= 1'b1;   // Read needs no data bytes
                                state_q         <= S_MEM_REQ;
                            end
                        end
                    end
                end
                S_DATA: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 3'(osiris_cfg_pkg::WORD_BYTES - 1)) begin
                            byte_cnt_q      <= '0;
                            mem_req_valid_o <= 1'b1;
                            state_q         <= S_MEM_REQ;
                        end
                    end
                end
                S_MEM_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_valid_o <= 1'b0;
                        state_q         <= S_MEM_REL;
                    end
                end
                S_MEM_REL: begin
                    if (!mem_ack_i) begin     // Bank has released
                        tx_req_o <= !we_q;
                        state_q  <= we_q ? S_IDLE : S_SEND;
                    end
                end
                S_SEND: begin
                    if (tx_ack_i) begin
                        tx_req_o   <= 1'b0;
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        state_q    <= S_SEND_REL;
                    end
                end
                default: begin
                    if (!tx_ack_i) begin
                        if (byte_cnt_q == 3'(osiris_cfg_pkg::WORD_BYTES)) begin
                            state_q <= S_IDLE;   // Whole word returned
                        end else begin
                            tx_req_o <= 1'b1;    // Next byte already on top
                            state_q  <= S_SEND;
                        end
                    end
                end
            endcase
        end
    end

    // --------------------
    // Frame payload
    // --------------------
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && frame_start) begin
            we_q  <= (rx_byte_i == osiris_cfg_pkg::CMD_WRITE);
            sel_q <= osiris_bus_pkg::mem_sel_t'(select_mem_i);   // Held for the frame
        end
        if (state_q == S_ADDR && rx_valid_i) begin
            addr_q <= {addr_q[7:0], rx_byte_i};                  // MSB first
        end
        if (state_q == S_DATA && rx_valid_i) begin
            word_q <= {word_q[23:0], rx_byte_i};
        end else if (state_q == S_MEM_REQ && mem_ack_i && !we_q) begin
            word_q <= mem_rsp_i.rdata;                           // Capture read word
        end else if (state_q == S_SEND && tx_ack_i) begin
            word_q <= {word_q[23:0], 8'h00};                     // Next byte to the top
        end
    end

    always_comb begin
        mem_req_o.sel   = sel_q;
        mem_req_o.we    = we_q;
        mem_req_o.addr  = addr_q;
        mem_req_o.wdata = word_q;
    end

    assign tx_byte_o = word_q[31:24];   // Response goes out MSB first

endmodule

//--- hdl/word_sram.sv
`timescale 1ns/1ns

module word_sram #(
    parameter int unsigned DEPTH = 512
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  logic                     we_i,      // 1 = write, 0 = read
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  osiris_bus_pkg::word_t    wdata_i,
    output osiris_bus_pkg::word_t    rdata_o    // Holds until the next enabled read
);

    osiris_bus_pkg::word_t mem_q [DEPTH];

    // Single port, one access per enabled clock
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];   // Registered read
            end
        end
    end

endmodule

//--- hdl/mem_bank.sv
`timescale 1ns/1ns

module mem_bank (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  osiris_bus_pkg::mem_req_t req_i,
    input  logic                     req_valid_i,
    output osiris_bus_pkg::mem_rsp_t rsp_o,
    output logic                     ack_o
);

    osiris_bus_pkg::mem_req_t                   req_q;       // Request as sampled
    logic                                       pending_q;   // Request already taken
    logic                                       access_q;    // Memory cycle this clock
    logic                                       sample;
    logic                                       inst_en;
    logic                                       data_en;
    logic [osiris_cfg_pkg::INST_ADDR_WIDTH-1:0] inst_addr;
    logic [osiris_cfg_pkg::DATA_ADDR_WIDTH-1:0] data_addr;
    osiris_bus_pkg::word_t                      inst_rdata;
    osiris_bus_pkg::word_t                      data_rdata;

    assign sample = req_valid_i && !pending_q;

    // --------------------
    // Four-phase responder
    // --------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            access_q  <= 1'b0;
            ack_o     <= 1'b0;
        end else begin
            access_q <= sample;
            if (sample) begin
                pending_q <= 1'b1;
            end else if (!req_valid_i) begin
                pending_q <= 1'b0;
            end
            if (access_q) begin
                ack_o <= 1'b1;            // Read data is out of the array now
            end else if (!req_valid_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            req_q <= req_i;
        end
    end

    // Decode and cut the index to each memory's width
    assign inst_en   = access_q && (req_q.sel == osiris_bus_pkg::INST_MEM);
    assign data_en   = access_q && (req_q.sel == osiris_bus_pkg::DATA_MEM);
    assign inst_addr = req_q.addr[osiris_cfg_pkg::INST_ADDR_WIDTH-1:0];
    assign data_addr = req_q.addr[osiris_cfg_pkg::DATA_ADDR_WIDTH-1:0];

    word_sram #(.DEPTH(osiris_cfg_pkg::INST_MEM_DEPTH)) u_inst_mem (
        .clk     (clk),
        .en_i    (inst_en),
        .we_i    (req_q.we),
        .addr_i  (inst_addr),
        .wdata_i (req_q.wdata),
        .rdata_o (inst_rdata)
    );

    word_sram #(.DEPTH(osiris_cfg_pkg::DATA_MEM_DEPTH)) u_data_mem (
        .clk     (clk),
        .en_i    (data_en),
        .we_i    (req_q.we),
        .addr_i  (data_addr),
        .wdata_i (req_q.wdata),
        .rdata_o (data_rdata)
    );

    assign rsp_o.rdata = (req_q.sel == osiris_bus_pkg::DATA_MEM) ? data_rdata : inst_rdata;

endmodule

//--- hdl/osiris_loader.sv
`timescale 1ns/1ns

module osiris_loader (
    input  logic clk,
    input  logic rst_n_i,
    input  logic uart_rx_i,      // Host serial in
    input  logic select_mem_i,   // 0 = instruction memory, 1 = data memory
    input  logic start_rx_i,     // Accept new command frames
    output logic uart_tx_o       // Host serial out
);

    osiris_bus_pkg::byte_t    rx_byte;
    logic                     rx_valid;
    osiris_bus_pkg::mem_req_t mem_req;
    logic                     mem_req_valid;
    osiris_bus_pkg::mem_rsp_t mem_rsp;
    logic                     mem_ack;
    osiris_bus_pkg::byte_t    tx_byte;
    logic                     tx_req;
    logic                     tx_ack;

    uart_rx u_uart_rx (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .rx_i    (uart_rx_i),
        .byte_o  (rx_byte),
        .valid_o (rx_valid)
    );

    // Frame parser, owns both handshakes
    uart_cmd_sequencer u_uart_cmd_sequencer (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rx_byte_i       (rx_byte),
        .rx_valid_i      (rx_valid),
        .select_mem_i    (select_mem_i),
        .start_rx_i      (start_rx_i),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_rsp_i       (mem_rsp),
        .mem_ack_i       (mem_ack),
        .tx_byte_o       (tx_byte),
        .tx_req_o        (tx_req),
        .tx_ack_i        (tx_ack)
    );

    mem_bank u_mem_bank (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (mem_req),
        .req_valid_i (mem_req_valid),
        .rsp_o       (mem_rsp),
        .ack_o       (mem_ack)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (tx_req),
        .byte_i  (tx_byte),
        .ack_o   (tx_ack),
        .tx_o    (uart_tx_o)
    );

endmodule

//--- sim/osiris_loader_props.sv
`timescale 1ns/1ns

module osiris_loader_props (
    input logic                     clk,
    input logic                     rst_n_i,
    input osiris_bus_pkg::mem_req_t req_i,
    input logic                     req_valid_i,
    input logic                     ack_i
);

    int unsigned fail_cnt = 0;   // Failed assertion attempts

    // Bank answers only a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_valid_i)
        else begin
            fail_cnt++;
            $error("mem_ack rose while mem_req_valid was low");
        end

    // Request struct frozen until the bank acknowledges
    req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_valid_i && !ack_i) |=> $stable(req_i))
        else begin
            fail_cnt++;
            $error("mem_req changed before mem_ack rose");
        end

    ack_release: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(req_valid_i) |=> !ack_i)   // Two cycles after req falls at most
        else begin
            fail_cnt++;
            $error("mem_ack still high two cycles after mem_req_valid fell");
        end

    sel_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_i |-> !$isunknown(req_i.sel))
        else begin
            fail_cnt++;
            $error("mem_req.sel is unknown while mem_req_valid is high");
        end

endmodule

//--- sim/osiris_loader_tb.sv
`timescale 1ns/1ns

module osiris_loader_tb;

    localparam int unsigned BIT_CLKS     = osiris_cfg_pkg::CLKS_PER_BIT;
    localparam int unsigned FRAME_CYCLES = 7 * 10 * BIT_CLKS;   // 7 bytes on the wire per exchange
    localparam int unsigned NUM_FRAMES   = 17;                  // Frames over all tests
    localparam int unsigned MAX_CYCLES   = 2 * NUM_FRAMES * FRAME_CYCLES;
    localparam int unsigned RX_WAIT      = 4 * 10 * BIT_CLKS;   // 3 command bytes plus turnaround

    logic        clk;
    logic        rst_n;
    logic        uart_rx;
    logic        select_mem;
    logic        start_rx;
    logic        uart_tx;
    int unsigned cycle_cnt = 0;
    int unsigned err_cnt   = 0;
    logic [15:0] lfsr_q    = 16'd92;   // Seed

    osiris_loader u_osiris_loader (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .uart_rx_i    (uart_rx),
        .select_mem_i (select_mem),
        .start_rx_i   (start_rx),
        .uart_tx_o    (uart_tx)
    );

    bind mem_bank osiris_loader_props u_props (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .ack_i       (ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
        $display("Verification failed");
        $finish;
    end

    // --------------------
    // Stimulus helpers
    // --------------------
    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic osiris_bus_pkg::word_t random_word();
        osiris_bus_pkg::word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w      = {w[30:0], lfsr_q[0]};   // One step per bit
        end
        return w;
    endfunction

    // Returns 10 ns after a rising edge
    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic send_byte(input osiris_bus_pkg::byte_t b);
        uart_rx = 1'b0;             // Start bit
        wait_cycles(BIT_CLKS);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];         // LSB first
            wait_cycles(BIT_CLKS);
        end
        uart_rx = 1'b1;             // Stop bit
        wait_cycles(BIT_CLKS);
    endtask

    task automatic send_cmd(input osiris_bus_pkg::byte_t cmd, input osiris_bus_pkg::mem_sel_t sel,
                            input logic [15:0] addr);
        select_mem = sel;           // Sampled with the command byte
        send_byte(cmd);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
    endtask

    task automatic write_word(input osiris_bus_pkg::mem_sel_t sel, input logic [15:0] addr,
                              input osiris_bus_pkg::word_t data);
        send_cmd(osiris_cfg_pkg::CMD_WRITE, sel, addr);
        for (int i = 3; i >= 0; i--) begin
            send_byte(data[i*8 +: 8]);
        end
    endtask

    task automatic receive_byte(input string name, output osiris_bus_pkg::byte_t b,
                                output logic ok);
        int unsigned waited;
        waited = 0;
        b      = '0;
        ok     = 1'b0;
        while (uart_tx && waited < RX_WAIT) begin
            wait_cycles(1);
            waited++;
        end
        if (uart_tx) begin
            err_cnt++;
            $display("%s: no response byte arrived within %0d cycles", name, RX_WAIT);
        end else begin
            wait_cycles(BIT_CLKS / 2);      // Middle of the start bit
            for (int i = 0; i < 8; i++) begin
                wait_cycles(BIT_CLKS);
                b[i] = uart_tx;
            end
            wait_cycles(BIT_CLKS);
            check_line({name, " stop bit"}, 1'b1, uart_tx);
            ok = 1'b1;
        end
    endtask

    task automatic read_word(input string name, input osiris_bus_pkg::mem_sel_t sel,
                             input logic [15:0] addr, output osiris_bus_pkg::word_t w);
        osiris_bus_pkg::byte_t b;
        logic                  ok;
        w = 'x;
        fork
            send_cmd(osiris_cfg_pkg::CMD_READ, sel, addr);
            begin
                ok = 1'b1;
                for (int i = 3; i >= 0 && ok; i--) begin   // MSB first
                    receive_byte(name, b, ok);
                    if (ok) begin
                        w[i*8 +: 8] = b;
                    end
                end
            end
        join
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_word(input string name, input osiris_bus_pkg::word_t exp,
                              input osiris_bus_pkg::word_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input osiris_bus_pkg::byte_t exp,
                              input osiris_bus_pkg::byte_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic idle_after_reset();
        for (int i = 0; i < 20; i++) begin
            check_line("idle_after_reset", 1'b1, uart_tx);
            wait_cycles(1);
        end
    endtask

    task automatic data_mem_roundtrip();
        logic [15:0]           addrs [3] = '{16'h0000, 16'h0123, 16'h01FF};
        osiris_bus_pkg::word_t wr;
        osiris_bus_pkg::word_t rd;
        foreach (addrs[i]) begin
            wr = random_word();
            write_word(osiris_bus_pkg::DATA_MEM, addrs[i], wr);
            read_word("data_mem_roundtrip", osiris_bus_pkg::DATA_MEM, addrs[i], rd);
            check_word("data_mem_roundtrip", wr, rd);
        end
    endtask

    task automatic inst_data_separation();
        osiris_bus_pkg::word_t inst_w;
        osiris_bus_pkg::word_t data_w;
        osiris_bus_pkg::word_t rd_inst;
        osiris_bus_pkg::word_t rd_data;
        inst_w = random_word();
        data_w = ~inst_w;           // Differs in every bit
        write_word(osiris_bus_pkg::INST_MEM, 16'h0010, inst_w);
        write_word(osiris_bus_pkg::DATA_MEM, 16'h0010, data_w);
        read_word("inst_data_separation", osiris_bus_pkg::INST_MEM, 16'h0010, rd_inst);
        read_word("inst_data_separation", osiris_bus_pkg::DATA_MEM, 16'h0010, rd_data);
        for (int i = 3; i >= 0; i--) begin
            check_byte("inst_data_separation inst", inst_w[i*8 +: 8], rd_inst[i*8 +: 8]);
            check_byte("inst_data_separation data", data_w[i*8 +: 8], rd_data[i*8 +: 8]);
        end
    endtask

    task automatic ignored_frames();
        osiris_bus_pkg::word_t kept;
        osiris_bus_pkg::word_t blocked;
        osiris_bus_pkg::word_t late;
        osiris_bus_pkg::word_t rd;
        kept    = random_word();
        blocked = random_word();
        late    = random_word();
        write_word(osiris_bus_pkg::DATA_MEM, 16'h0040, kept);
        start_rx = 1'b0;            // Whole frame arrives while blocked
        write_word(osiris_bus_pkg::DATA_MEM, 16'h0040, blocked);
        start_rx = 1'b1;
        read_word("ignored_frames start_rx low", osiris_bus_pkg::DATA_MEM, 16'h0040, rd);
        check_word("ignored_frames start_rx low", kept, rd);
        send_byte(8'h55);           // Neither read nor write
        write_word(osiris_bus_pkg::DATA_MEM, 16'h0041, late);
        read_word("ignored_frames unknown command", osiris_bus_pkg::DATA_MEM, 16'h0041, rd);
        check_word("ignored_frames unknown command", late, rd);
    endtask

    task automatic address_alias();
        osiris_bus_pkg::word_t w;
        osiris_bus_pkg::word_t rd;
        w = random_word();
        write_word(osiris_bus_pkg::DATA_MEM, 16'h0005 + 16'd512, w);   // Cut to 9 bits
        read_word("address_alias", osiris_bus_pkg::DATA_MEM, 16'h0005, rd);
        check_word("address_alias", w, rd);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int unsigned assert_errs;
        rst_n      = 1'b0;
        uart_rx    = 1'b1;          // Idle line
        select_mem = 1'b0;
        start_rx   = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        idle_after_reset();
        data_mem_roundtrip();
        inst_data_separation();
        ignored_frames();
        address_alias();
        assert_errs = u_osiris_loader.u_mem_bank.u_props.fail_cnt;
        $display("Check errors: %0d, assertion errors: %0d", err_cnt, assert_errs);
        if (err_cnt == 0 && assert_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- osiris_loader.f
hdl/osiris_cfg_pkg.sv
hdl/osiris_bus_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_cmd_sequencer.sv
hdl/word_sram.sv
hdl/mem_bank.sv
hdl/osiris_loader.sv
sim/osiris_loader_props.sv
sim/osiris_loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash

TOP=osiris_loader_tb
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" \
    -f osiris_loader.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
